// ==== common/pbch_pkg.sv ====
`default_nettype none

package pbch_pkg;

    localparam int GOLD_LEN = 31;
    localparam int GOLD_SKIP = 1600;
    localparam int NUM_IBAR = 8;
    localparam int NUM_PILOTS = 64;
    localparam int SC_PER_SYM = 256;
    localparam int PILOT_SPACING = 4;
    localparam int CORR_W = 9;
    localparam int IQ_W = 16;

    typedef logic [9:0] cell_id_t;
    typedef logic [$clog2(NUM_IBAR)-1:0] ibar_t;
    // bit 1 carries the even Gold bit, bit 0 the odd one
    typedef logic [1:0] dmrs_sym_t;
    typedef logic [$clog2(NUM_PILOTS)-1:0] pilot_idx_t;
    typedef logic [$clog2(SC_PER_SYM)-1:0] sc_idx_t;
    typedef logic signed [CORR_W-1:0] corr_t;
    typedef logic [GOLD_LEN-1:0] gold_state_t;

    // x1 uses x^31 + x^3 + 1, x2 uses x^31 + x^3 + x^2 + x + 1
    localparam gold_state_t X1_TAPS = gold_state_t'(31'h0000_0009);
    localparam gold_state_t X2_TAPS = gold_state_t'(31'h0000_000F);

    typedef struct packed {
        logic signed [IQ_W-1:0] im;
        logic signed [IQ_W-1:0] re;
    } iq_sample_t;

    typedef struct packed {
        dmrs_sym_t [NUM_IBAR-1:0] sym;
    } dmrs_row_t;

    typedef struct packed {
        logic       en;
        pilot_idx_t addr;
        dmrs_row_t  row;
    } dmrs_wr_t;

    typedef struct packed {
        logic      valid;
        logic      re_neg;
        logic      im_neg;
        dmrs_row_t row;
    } pilot_t;

    typedef enum logic [2:0] {GEN_IDLE, GEN_LOAD, GEN_SKIP, GEN_STORE, GEN_DONE} gen_state_t;
    typedef enum logic {TRK_IDLE, TRK_SYMBOL} trk_state_t;
    typedef enum logic {COR_ACCUM, COR_DECIDE} cor_state_t;

endpackage

`default_nettype wire

// ==== gold_sequence/gold_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module gold_lfsr
    import pbch_pkg::*;
#(
    parameter gold_state_t TAPS = X1_TAPS
) (
    input  wire logic        clk_i,
    input  wire logic        reset_ni,
    input  wire logic        load_i,
    input  wire gold_state_t seed_i,
    input  wire logic        step_i,
    output logic             bit_o
);

    // lfsr_q[i] holds x(n + i), so bit 0 is the oldest bit of the window
    gold_state_t lfsr_q;
    logic        feedback;

    assign feedback = ^(lfsr_q & TAPS);
    assign bit_o = lfsr_q[0];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lfsr_q <= '0;
        end else if (load_i) begin
            lfsr_q <= seed_i;
        end else if (step_i) begin
            lfsr_q <= {feedback, lfsr_q[GOLD_LEN-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== gold_sequence/dmrs_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmrs_generator
    import pbch_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_ni,
    input  wire logic     n_id_valid_i,
    input  wire cell_id_t n_id_i,
    output dmrs_wr_t      wr_o,
    output logic          ready_o
);

    gen_state_t                     state;
    logic [$clog2(GOLD_SKIP)-1:0]   cnt;
    logic                           ready_q;
    cell_id_t                       n_id_q;
    logic                           lfsr_load;
    logic                           lfsr_step;
    logic                           x1_bit;
    logic [NUM_IBAR-1:0]            x2_bit;
    logic [NUM_IBAR-1:0]            gold_bit;
    logic [NUM_IBAR-1:0]            even_q;

    // c_init for the PBCH DMRS of SSB index ibar
    function automatic gold_state_t c_init_of(input cell_id_t n_id, input int ibar);
        int c;
        c = (ibar + 1) * (int'(n_id >> 2) + 1) * 2048 + (ibar + 1) * 64 + int'(n_id[1:0]);
        return gold_state_t'(c);
    endfunction

    assign lfsr_load = (state == GEN_LOAD);
    assign lfsr_step = (state == GEN_SKIP) || (state == GEN_STORE);
    assign gold_bit = x2_bit ^ {NUM_IBAR{x1_bit}};
    assign ready_o = ready_q;

    gold_lfsr #(
        .TAPS(X1_TAPS)
    ) x1_lfsr_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .load_i(lfsr_load),
        .seed_i(gold_state_t'(1)),
        .step_i(lfsr_step),
        .bit_o(x1_bit)
    );

    for (genvar g = 0; g < NUM_IBAR; g++) begin : gen_x2
        gold_lfsr #(
            .TAPS(X2_TAPS)
        ) x2_lfsr_inst (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .load_i(lfsr_load),
            .seed_i(c_init_of(n_id_q, g)),
            .step_i(lfsr_step),
            .bit_o(x2_bit[g])
        );
    end

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            n_id_q <= n_id_i;
        end
        // the even bit waits here until its odd partner is out
        if (state == GEN_STORE && !cnt[0]) begin
            even_q <= gold_bit;
        end
    end

    // one row per candidate pair, written on the odd bit
    always_comb begin
        wr_o.en = (state == GEN_STORE) && cnt[0];
        wr_o.addr = pilot_idx_t'(cnt >> 1);
        for (int i = 0; i < NUM_IBAR; i++) begin
            wr_o.row.sym[i] = {even_q[i], gold_bit[i]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= GEN_IDLE;
            cnt <= '0;
            ready_q <= 1'b0;
        end else if (n_id_valid_i) begin
            // a new cell id restarts the whole run
            state <= GEN_LOAD;
            cnt <= '0;
            ready_q <= 1'b0;
        end else begin
            case (state)
                GEN_LOAD: state <= GEN_SKIP;
                GEN_SKIP: begin
                    if (int'(cnt) == GOLD_SKIP - 1) begin
                        cnt <= '0;
                        state <= GEN_STORE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                GEN_STORE: begin
                    if (int'(cnt) == 2 * NUM_PILOTS - 1) begin
                        cnt <= '0;
                        ready_q <= 1'b1;
                        state <= GEN_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // idle and done wait for the next cell id
                default: state <= state;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/dmrs_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmrs_table
    import pbch_pkg::*;
(
    input  wire logic       clk_i,
    input  wire dmrs_wr_t   wr_i,
    input  wire pilot_idx_t rd_addr_i,
    output dmrs_row_t       rd_row_o
);

    // row m holds pilot m of the first PBCH symbol for all eight SSB indices
    dmrs_row_t mem [NUM_PILOTS];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.row;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_row_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== source/pilot_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pilot_tracker
    import pbch_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_ni,
    input  wire logic       start_i,
    input  wire logic       ready_i,
    input  wire iq_sample_t sample_i,
    input  wire logic       sample_valid_i,
    input  wire logic [1:0] nu_i,
    output pilot_idx_t      rd_addr_o,
    input  wire dmrs_row_t  rd_row_i,
    output pilot_t          pilot_o,
    output logic            sym_done_o
);

    trk_state_t state;
    sc_idx_t    sc_cnt;
    pilot_idx_t pilot_cnt;
    logic       starting;
    logic       take;
    logic       is_pilot;
    logic       last;
    logic       pilot_valid_q;
    logic       re_neg_q;
    logic       im_neg_q;
    logic       sym_done_q;

    // a start pulse counts only when the table is complete and no symbol is running
    always_comb begin
        starting = (state == TRK_IDLE) && start_i && ready_i;
        take = (starting || state == TRK_SYMBOL) && sample_valid_i;
        is_pilot = take && (sc_cnt[$clog2(PILOT_SPACING)-1:0] == nu_i);
        last = take && (state == TRK_SYMBOL) && (sc_cnt == sc_idx_t'(SC_PER_SYM - 1));
    end

    assign rd_addr_o = pilot_cnt;
    assign sym_done_o = sym_done_q;

    // the signs are delayed one cycle to meet the registered table read
    always_ff @(posedge clk_i) begin
        re_neg_q <= sample_i.re[IQ_W-1];
        im_neg_q <= sample_i.im[IQ_W-1];
    end

    always_comb begin
        pilot_o.valid = pilot_valid_q;
        pilot_o.re_neg = re_neg_q;
        pilot_o.im_neg = im_neg_q;
        pilot_o.row = rd_row_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= TRK_IDLE;
            sc_cnt <= '0;
            pilot_cnt <= '0;
            pilot_valid_q <= 1'b0;
            sym_done_q <= 1'b0;
        end else begin
            pilot_valid_q <= is_pilot;
            sym_done_q <= last;
            if (take) begin
                sc_cnt <= sc_cnt + 1'b1;
            end
            if (is_pilot) begin
                pilot_cnt <= pilot_cnt + 1'b1;
            end
            case (state)
                TRK_IDLE: begin
                    if (starting) begin
                        state <= TRK_SYMBOL;
                    end
                end
                TRK_SYMBOL: begin
                    if (last) begin
                        state <= TRK_IDLE;
                        sc_cnt <= '0;
                        pilot_cnt <= '0;
                    end
                end
                default: state <= TRK_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/ibar_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibar_correlator
    import pbch_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   reset_ni,
    input  wire pilot_t pilot_i,
    input  wire logic   sym_done_i,
    output ibar_t       ibar_ssb_o,
    output logic        ibar_valid_o
);

    cor_state_t state;
    corr_t      acc [NUM_IBAR];
    corr_t      acc_rot [NUM_IBAR];
    dmrs_sym_t  demod;
    dmrs_sym_t  demod_rot;
    ibar_t      best_idx;
    corr_t      best_mag;

    // +1 for each matching bit, -1 for each differing bit
    function automatic corr_t score(input dmrs_sym_t rx, input dmrs_sym_t ref_sym);
        corr_t s;
        s = '0;
        for (int b = 0; b < 2; b++) begin
            if (rx[b] == ref_sym[b]) begin
                s = s + corr_t'(1);
            end else begin
                s = s - corr_t'(1);
            end
        end
        return s;
    endfunction

    function automatic corr_t magnitude(input corr_t v);
        return v[CORR_W-1] ? -v : v;
    endfunction

    function automatic corr_t larger(input corr_t a, input corr_t b);
        return (a > b) ? a : b;
    endfunction

    // hard QPSK decision, plain and turned by 90 degrees
    assign demod = {pilot_i.re_neg, pilot_i.im_neg};
    assign demod_rot = {~pilot_i.im_neg, pilot_i.re_neg};

    // first index with a strictly larger peak wins, so ties keep the lower index
    always_comb begin
        corr_t cand;
        best_idx = '0;
        best_mag = larger(magnitude(acc[0]), magnitude(acc_rot[0]));
        for (int i = 1; i < NUM_IBAR; i++) begin
            cand = larger(magnitude(acc[i]), magnitude(acc_rot[i]));
            if (cand > best_mag) begin
                best_mag = cand;
                best_idx = ibar_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= COR_ACCUM;
            ibar_ssb_o <= '0;
            ibar_valid_o <= 1'b0;
            for (int i = 0; i < NUM_IBAR; i++) begin
                acc[i] <= '0;
                acc_rot[i] <= '0;
            end
        end else begin
            ibar_valid_o <= 1'b0;
            for (int i = 0; i < NUM_IBAR; i++) begin
                // a pilot of the next symbol may already arrive while deciding
                if (state == COR_DECIDE) begin
                    acc[i] <= pilot_i.valid ? score(demod, pilot_i.row.sym[i]) : '0;
                    acc_rot[i] <= pilot_i.valid ? score(demod_rot, pilot_i.row.sym[i]) : '0;
                end else if (pilot_i.valid) begin
                    acc[i] <= acc[i] + score(demod, pilot_i.row.sym[i]);
                    acc_rot[i] <= acc_rot[i] + score(demod_rot, pilot_i.row.sym[i]);
                end
            end
            case (state)
                COR_ACCUM: begin
                    if (sym_done_i) begin
                        state <= COR_DECIDE;
                    end
                end
                COR_DECIDE: begin
                    ibar_ssb_o <= best_idx;
                    ibar_valid_o <= 1'b1;
                    state <= COR_ACCUM;
                end
                default: state <= COR_ACCUM;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pbch_ibar_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_ibar_detector
    import pbch_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_ni,
    input  wire iq_sample_t sample_i,
    input  wire logic       sample_valid_i,
    input  wire cell_id_t   n_id_i,
    input  wire logic       n_id_valid_i,
    input  wire logic       pbch_start_i,
    output logic            dmrs_ready_o,
    output ibar_t           ibar_ssb_o,
    output logic            ibar_valid_o
);

    logic [1:0] nu_q;
    dmrs_wr_t   dmrs_wr;
    pilot_idx_t rd_addr;
    dmrs_row_t  rd_row;
    pilot_t     pilot;
    logic       sym_done;

    // nu is the pilot offset within each group of four subcarriers
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            nu_q <= '0;
        end else if (n_id_valid_i) begin
            nu_q <= n_id_i[1:0];
        end
    end

    dmrs_generator dmrs_generator_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .n_id_valid_i(n_id_valid_i),
        .n_id_i(n_id_i),
        .wr_o(dmrs_wr),
        .ready_o(dmrs_ready_o)
    );

    dmrs_table dmrs_table_inst (
        .clk_i(clk_i),
        .wr_i(dmrs_wr),
        .rd_addr_i(rd_addr),
        .rd_row_o(rd_row)
    );

    pilot_tracker pilot_tracker_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .start_i(pbch_start_i),
        .ready_i(dmrs_ready_o),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .nu_i(nu_q),
        .rd_addr_o(rd_addr),
        .rd_row_i(rd_row),
        .pilot_o(pilot),
        .sym_done_o(sym_done)
    );

    ibar_correlator ibar_correlator_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .pilot_i(pilot),
        .sym_done_i(sym_done),
        .ibar_ssb_o(ibar_ssb_o),
        .ibar_valid_o(ibar_valid_o)
    );

endmodule

`default_nettype wire

// ==== verification/pbch_ibar_detector_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_ibar_detector_properties (
    input wire logic clk_i,
    input wire logic reset_ni,
    input wire logic n_id_valid_i,
    input wire logic dmrs_ready_o,
    input wire logic ibar_valid_o
);

    // high once the table was complete at some point since the last decision
    logic ready_since_pulse;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ready_since_pulse <= 1'b0;
        end else if (ibar_valid_o) begin
            ready_since_pulse <= dmrs_ready_o;
        end else if (dmrs_ready_o) begin
            ready_since_pulse <= 1'b1;
        end
    end

    valid_single_cycle: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o)
        else $error("ibar_valid_o stayed high for two cycles");

    ready_falls_on_new_id: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $fell(dmrs_ready_o) |-> $past(n_id_valid_i))
        else $error("dmrs_ready_o fell without a new cell id");

    no_result_without_table: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(ibar_valid_o) |-> (ready_since_pulse || dmrs_ready_o))
        else $error("ibar_valid_o rose while the table was never ready");

endmodule

bind pbch_ibar_detector pbch_ibar_detector_properties pbch_ibar_detector_properties_inst (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .n_id_valid_i(n_id_valid_i),
    .dmrs_ready_o(dmrs_ready_o),
    .ibar_valid_o(ibar_valid_o)
);

`default_nettype wire

// ==== verification/pbch_ibar_detector_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pbch_ibar_detector_tb
    import pbch_pkg::*;
;

    localparam int CLK_PERIOD_NS = 10;
    localparam int NUM_IDS = 4;
    localparam int SYMS_PER_ID = 6;
    localparam int SEQ_LEN = GOLD_SKIP + 2 * NUM_PILOTS;
    // one generation plus a generous slot per symbol, for every cell id and the extra restart
    localparam int RUN_CYCLES = SEQ_LEN + SYMS_PER_ID * 2 * SC_PER_SYM;
    localparam int WATCHDOG_CYCLES = (NUM_IDS + 1) * RUN_CYCLES + 2000;

    logic       clk_i = 1'b0;
    logic       reset_ni;
    iq_sample_t sample_i;
    logic       sample_valid_i;
    cell_id_t   n_id_i;
    logic       n_id_valid_i;
    logic       pbch_start_i;
    logic       dmrs_ready_o;
    ibar_t      ibar_ssb_o;
    logic       ibar_valid_o;

    logic [31:0] rng_state;
    logic [1:0]  cur_nu;
    dmrs_sym_t   model_sym [NUM_PILOTS][NUM_IBAR];
    logic        pil_re [NUM_PILOTS];
    logic        pil_im [NUM_PILOTS];
    logic [31:0] samples [SC_PER_SYM];
    ibar_t       exp_q [$];
    ibar_t       expected_ibar;
    int          errors = 0;
    int          checks = 0;
    int          pulses_seen = 0;
    int          symbols_accepted = 0;

    pbch_ibar_detector pbch_ibar_detector_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .pbch_start_i(pbch_start_i),
        .dmrs_ready_o(dmrs_ready_o),
        .ibar_ssb_o(ibar_ssb_o),
        .ibar_valid_o(ibar_valid_o)
    );

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[ERROR] %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
        errors++;
    endtask

    // the standard Gold recurrences, run past the 1600-bit skip for every candidate
    task automatic build_model(input cell_id_t n_id);
        logic x1 [SEQ_LEN];
        logic x2 [SEQ_LEN];
        int   c_init;
        int   e;
        for (int i = 0; i < NUM_IBAR; i++) begin
            c_init = 2048 * (i + 1) * (int'(n_id) / 4 + 1) + 64 * (i + 1) + int'(n_id) % 4;
            for (int n = 0; n < GOLD_LEN; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (int n = 0; n < SEQ_LEN - GOLD_LEN; n++) begin
                x1[n + GOLD_LEN] = x1[n + 3] ^ x1[n];
                x2[n + GOLD_LEN] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
            end
            for (int m = 0; m < NUM_PILOTS; m++) begin
                e = GOLD_SKIP + 2 * m;
                model_sym[m][i] = {x1[e] ^ x2[e], x1[e + 1] ^ x2[e + 1]};
            end
        end
    endtask

    // correlate hard decisions against every candidate, plain and turned by 90 degrees
    function automatic ibar_t model_argmax();
        int         acc;
        int         rot;
        int         peak;
        int         best_peak;
        ibar_t      best;
        logic [1:0] d;
        logic [1:0] r;
        best = '0;
        best_peak = -1;
        for (int i = 0; i < NUM_IBAR; i++) begin
            acc = 0;
            rot = 0;
            for (int m = 0; m < NUM_PILOTS; m++) begin
                d = {pil_re[m], pil_im[m]};
                r = {~pil_im[m], pil_re[m]};
                for (int b = 0; b < 2; b++) begin
                    acc += (d[b] == model_sym[m][i][b]) ? 1 : -1;
                    rot += (r[b] == model_sym[m][i][b]) ? 1 : -1;
                end
            end
            acc = (acc < 0) ? -acc : acc;
            rot = (rot < 0) ? -rot : rot;
            peak = (acc > rot) ? acc : rot;
            if (peak > best_peak) begin
                best_peak = peak;
                best = ibar_t'(i);
            end
        end
        return best;
    endfunction

    task automatic set_cell_id(input cell_id_t id);
        n_id_i <= id;
        n_id_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_valid_i <= 1'b0;
        @(posedge clk_i);
        checks++;
        if (dmrs_ready_o !== 1'b0) begin
            report_mismatch("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
        end
        cur_nu = id[1:0];
    endtask

    task automatic wait_ready();
        while (dmrs_ready_o !== 1'b1) begin
            @(posedge clk_i);
        end
        checks++;
    endtask

    // mode 0 carries clean pilot signs, mode 1 rotated signs, mode 2 random samples
    task automatic drive_symbol(input int mode, input ibar_t chosen, input bit accept,
                                input bit mid_start);
        logic [31:0] s;
        logic [31:0] r;
        int          mid_k;
        int          m;
        dmrs_sym_t   ref_sym;
        r = next_rand();
        mid_k = 1 + int'(r[7:0]) % 255;
        for (int k = 0; k < SC_PER_SYM; k++) begin
            s = next_rand();
            if (k % PILOT_SPACING == int'(cur_nu)) begin
                m = k / PILOT_SPACING;
                ref_sym = model_sym[m][chosen];
                if (mode == 0) begin
                    s[15] = ref_sym[1];
                    s[31] = ref_sym[0];
                end else if (mode == 1) begin
                    s[31] = ~ref_sym[1];
                    s[15] = ref_sym[0];
                end
                pil_re[m] = s[15];
                pil_im[m] = s[31];
            end
            samples[k] = s;
        end
        if (accept) begin
            expected_ibar = (mode == 2) ? model_argmax() : chosen;
            exp_q.push_back(expected_ibar);
            symbols_accepted++;
        end
        for (int k = 0; k < SC_PER_SYM; k++) begin
            r = next_rand();
            while (k > 0 && r[2:0] == 3'd0) begin
                sample_valid_i <= 1'b0;
                pbch_start_i <= 1'b0;
                @(posedge clk_i);
                r = next_rand();
            end
            sample_i <= iq_sample_t'(samples[k]);
            sample_valid_i <= 1'b1;
            pbch_start_i <= (k == 0) || (mid_start && (k == mid_k));
            @(posedge clk_i);
        end
        sample_valid_i <= 1'b0;
        pbch_start_i <= 1'b0;
        if (accept) begin
            do begin
                @(posedge clk_i);
            end while (ibar_valid_o !== 1'b1);
        end
    endtask

    // every pulse must match the oldest accepted symbol
    always @(posedge clk_i) begin
        if (reset_ni === 1'b1 && ibar_valid_o === 1'b1) begin
            pulses_seen++;
            if (exp_q.size() == 0) begin
                $display("ibar_valid_o pulsed at %0t ns with no accepted symbol waiting", $time);
                errors++;
            end else begin
                expected_ibar = exp_q.pop_front();
                checks++;
                if (ibar_ssb_o !== expected_ibar) begin
                    report_mismatch("ibar_ssb_o", 32'(ibar_ssb_o), 32'(expected_ibar));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        cell_id_t id;
        rng_state = 32'd93;
        cur_nu = 2'd0;
        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(posedge clk_i);
        checks++;
        if (dmrs_ready_o !== 1'b0) begin
            report_mismatch("dmrs_ready_o", 32'(dmrs_ready_o), 32'd0);
        end
        if (ibar_valid_o !== 1'b0) begin
            report_mismatch("ibar_valid_o", 32'(ibar_valid_o), 32'd0);
        end
        if (ibar_ssb_o !== '0) begin
            report_mismatch("ibar_ssb_o", 32'(ibar_ssb_o), 32'd0);
        end
        for (int run = 0; run < NUM_IDS; run++) begin
            id = cell_id_t'(next_rand() % 32'd1008);
            set_cell_id(id);
            if (run == 0) begin
                // start while the table is still being built, then restart generation
                drive_symbol(2, '0, 1'b0, 1'b0);
                id = cell_id_t'(next_rand() % 32'd1008);
                set_cell_id(id);
            end
            wait_ready();
            build_model(id);
            for (int sym = 0; sym < SYMS_PER_ID; sym++) begin
                drive_symbol(sym % 3, ibar_t'(next_rand() % 32'd8), 1'b1, sym == 4);
            end
        end
        repeat (5) @(posedge clk_i);
        if (pulses_seen != symbols_accepted) begin
            $display("ibar_valid_o pulsed %0d times for %0d accepted symbols",
                     pulses_seen, symbols_accepted);
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/pbch_pkg.sv
gold_sequence/gold_lfsr.sv
gold_sequence/dmrs_generator.sv
source/dmrs_table.sv
source/pilot_tracker.sv
source/ibar_correlator.sv
source/pbch_ibar_detector.sv
verification/pbch_ibar_detector_properties.sv
verification/pbch_ibar_detector_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module pbch_ibar_detector_tb \
    -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vpbch_ibar_detector_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
